// File: verilog/route_table_pkg.sv
// ==============================
// Sizes and vector types shared by the route table blocks.
// Modules refer to these by scoped name.
// ==============================
`default_nettype none

package route_table_pkg;

  // Crossbar ports and insertion sources
  localparam int NUM_PORTS   = 4;
  localparam int PORT_W      = 2;
  localparam int NUM_INS_SRC = NUM_PORTS + 1;
  localparam int INS_SRC_W   = 3;

  // Table size
  localparam int TABLE_DEPTH_LOG2 = 6;
  localparam int TABLE_DEPTH      = 1 << TABLE_DEPTH_LOG2;

  // Endpoint ID, the lookup key
  typedef logic [15:0] epid_t;
  // Output port number, the stored value
  typedef logic [PORT_W-1:0] port_t;
  // Insertion data word, only the low PORT_W bits matter
  typedef logic [31:0] cfg_data_t;
  typedef logic [TABLE_DEPTH_LOG2-1:0] entry_idx_t;

endpackage

`default_nettype wire

// File: verilog/insert_request_port.sv
// ==============================
// Capture register for one insertion source. Holds a write
// until the insert arbiter takes it, then acknowledges.
// ==============================
`timescale 1ns/100ps
`default_nettype none

module insert_request_port (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       req_wr,
  input  wire route_table_pkg::epid_t     req_addr,
  input  wire route_table_pkg::cfg_data_t req_data,
  input  wire logic                       take,
  output logic                            held_valid,
  output route_table_pkg::epid_t          held_epid,
  output route_table_pkg::port_t          held_port,
  output logic                            resp_ack
);

  // Valid flag, strobes while holding are dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else if (!held_valid) begin
      held_valid <= req_wr;
    end else if (take) begin
      held_valid <= 1'b0;
    end
  end

  // Address and port bits of the data word
  always_ff @(posedge clk) begin
    if (!held_valid && req_wr) begin
      held_epid <= req_addr;
      held_port <= req_data[route_table_pkg::PORT_W-1:0];
    end
  end

  // Ack in the same cycle the arbiter takes the request
  assign resp_ack = take & held_valid;

  // Arbiter may only take a request that is being held
  take_needs_held : assert property (
    @(posedge clk) disable iff (reset)
    take |-> held_valid
  );

endmodule

`default_nettype wire

// File: verilog/insert_arbiter.sv
// ==============================
// Round-robin pick among the insertion sources into a
// one-entry buffer that feeds the route table insert port.
// ==============================
`timescale 1ns/100ps
`default_nettype none

module insert_arbiter (
  input  wire logic                                                   clk,
  input  wire logic                                                   reset,
  input  wire logic [route_table_pkg::NUM_INS_SRC-1:0]                src_valid,
  input  wire route_table_pkg::epid_t [route_table_pkg::NUM_INS_SRC-1:0] src_epid,
  input  wire route_table_pkg::port_t [route_table_pkg::NUM_INS_SRC-1:0] src_port,
  input  wire logic                                                   ins_ready,
  output logic [route_table_pkg::NUM_INS_SRC-1:0]                     src_take,
  output logic                                                        ins_valid,
  output route_table_pkg::epid_t                                      ins_epid,
  output route_table_pkg::port_t                                      ins_port
);

  logic [route_table_pkg::INS_SRC_W-1:0] last_q;
  logic [route_table_pkg::INS_SRC_W-1:0] grant_idx;
  logic                                  grant_found;
  logic                                  can_accept;
  logic                                  accept;
  logic                                  buf_valid;
  route_table_pkg::epid_t                buf_epid;
  route_table_pkg::port_t                buf_port;

  // Search starts just after the last winner, nearest valid wins
  always_comb begin
    int j;
    grant_found = 1'b0;
    grant_idx   = last_q;
    for (int k = route_table_pkg::NUM_INS_SRC; k >= 1; k--) begin
      j = (int'(last_q) + k) % route_table_pkg::NUM_INS_SRC;
      if (src_valid[j]) begin
        grant_found = 1'b1;
        grant_idx   = j[route_table_pkg::INS_SRC_W-1:0];
      end
    end
  end

  // Buffer is free, or drains this cycle
  assign can_accept = !buf_valid || ins_ready;
  assign accept     = grant_found && can_accept;

  always_comb begin
    src_take = '0;
    if (accept) begin
      src_take[grant_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      buf_valid <= 1'b0;
      last_q    <= route_table_pkg::INS_SRC_W'(route_table_pkg::NUM_INS_SRC - 1);
    end else if (accept) begin
      buf_valid <= 1'b1;
      last_q    <= grant_idx;
    end else if (ins_ready) begin
      buf_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      buf_epid <= src_epid[grant_idx];
      buf_port <= src_port[grant_idx];
    end
  end

  assign ins_valid = buf_valid;
  assign ins_epid  = buf_epid;
  assign ins_port  = buf_port;

  one_take : assert property (@(posedge clk) disable iff (reset) $onehot0(src_take));

  // Stalled buffer must not change under the table
  buf_stable : assert property (
    @(posedge clk) disable iff (reset)
    (ins_valid && !ins_ready) |=> (ins_valid && $stable(ins_epid) && $stable(ins_port))
  );

endmodule

`default_nettype wire

// File: verilog/route_cam.sv
// ==============================
// Content-addressed endpoint to port table. One insert port
// with a two-state write machine, one registered lookup port.
// ==============================
`timescale 1ns/100ps
`default_nettype none

module route_cam (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   ins_valid,
  input  wire route_table_pkg::epid_t ins_epid,
  input  wire route_table_pkg::port_t ins_port,
  input  wire logic                   lk_valid,
  input  wire route_table_pkg::epid_t lk_epid,
  output logic                        ins_ready,
  output route_table_pkg::port_t      lk_port,
  output logic                        lk_hit
);

  typedef enum logic {
    ins_idle,
    ins_write
  } ins_state_t;

  ins_state_t ins_state;

  logic [route_table_pkg::TABLE_DEPTH-1:0] entry_valid;
  route_table_pkg::epid_t                  entry_key  [route_table_pkg::TABLE_DEPTH];
  route_table_pkg::port_t                  entry_port [route_table_pkg::TABLE_DEPTH];

  // Insert held while the write is decided
  route_table_pkg::epid_t     wr_epid;
  route_table_pkg::port_t     wr_port;
  route_table_pkg::entry_idx_t repl_ptr;
  route_table_pkg::entry_idx_t match_idx;
  route_table_pkg::entry_idx_t free_idx;
  route_table_pkg::entry_idx_t wr_idx;
  logic                        wr_replace;

  logic [route_table_pkg::TABLE_DEPTH-1:0] wr_match;
  logic [route_table_pkg::TABLE_DEPTH-1:0] lk_match;
  route_table_pkg::port_t                  lk_sel_port;

  // Parallel key compare for both ports
  always_comb begin
    for (int i = 0; i < route_table_pkg::TABLE_DEPTH; i++) begin
      wr_match[i] = entry_valid[i] && (entry_key[i] == wr_epid);
      lk_match[i] = entry_valid[i] && (entry_key[i] == lk_epid);
    end
  end

  // Lowest free slot wins, so scan downward
  always_comb begin
    match_idx   = '0;
    free_idx    = '0;
    lk_sel_port = '0;
    for (int i = route_table_pkg::TABLE_DEPTH - 1; i >= 0; i--) begin
      if (wr_match[i]) begin
        match_idx = route_table_pkg::entry_idx_t'(i);
      end
      if (!entry_valid[i]) begin
        free_idx = route_table_pkg::entry_idx_t'(i);
      end
      if (lk_match[i]) begin
        lk_sel_port = lk_sel_port | entry_port[i];
      end
    end
  end

  // Overwrite first, then a free slot, then evict the oldest
  always_comb begin
    wr_idx     = repl_ptr;
    wr_replace = 1'b1;
    if (|wr_match) begin
      wr_idx     = match_idx;
      wr_replace = 1'b0;
    end else if (!(&entry_valid)) begin
      wr_idx     = free_idx;
      wr_replace = 1'b0;
    end
  end

  assign ins_ready = (ins_state == ins_idle);

  always_ff @(posedge clk) begin
    if (reset) begin
      ins_state   <= ins_idle;
      entry_valid <= '0;
      repl_ptr    <= '0;
    end else begin
      case (ins_state)
        ins_idle: begin
          if (ins_valid) begin
            ins_state <= ins_write;
          end
        end
        ins_write: begin
          entry_valid[wr_idx] <= 1'b1;
          if (wr_replace) begin
            repl_ptr <= repl_ptr + 1'b1;
          end
          ins_state <= ins_idle;
        end
        default: ins_state <= ins_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ins_state == ins_idle && ins_valid) begin
      wr_epid <= ins_epid;
      wr_port <= ins_port;
    end
    if (ins_state == ins_write) begin
      entry_key[wr_idx]  <= wr_epid;
      entry_port[wr_idx] <= wr_port;
    end
  end

  // Lookup result, port reads as zero on a miss
  always_ff @(posedge clk) begin
    if (reset) begin
      lk_hit <= 1'b0;
    end else if (lk_valid) begin
      lk_hit <= |lk_match;
    end
  end

  always_ff @(posedge clk) begin
    if (lk_valid) begin
      lk_port <= lk_sel_port;
    end
  end

  // Keys stay unique across all inserts
  unique_keys : assert property (
    @(posedge clk) disable iff (reset)
    lk_valid |-> $onehot0(lk_match)
  );

endmodule

`default_nettype wire

// File: verilog/find_arbiter.sv
// ==============================
// Shares the table lookup among the lookup channels, one
// request at a time, and returns each answer to its channel.
// ==============================
`timescale 1ns/100ps
`default_nettype none

module find_arbiter (
  input  wire logic                                                 clk,
  input  wire logic                                                 reset,
  input  wire logic [route_table_pkg::NUM_PORTS-1:0]                find_valid,
  input  wire route_table_pkg::epid_t [route_table_pkg::NUM_PORTS-1:0] find_epid,
  input  wire logic [route_table_pkg::NUM_PORTS-1:0]                result_ready,
  input  wire route_table_pkg::port_t                               lk_port,
  input  wire logic                                                 lk_hit,
  output logic [route_table_pkg::NUM_PORTS-1:0]                     find_ready,
  output logic [route_table_pkg::NUM_PORTS-1:0]                     result_valid,
  output route_table_pkg::port_t [route_table_pkg::NUM_PORTS-1:0]   result_port,
  output logic [route_table_pkg::NUM_PORTS-1:0]                     result_hit,
  output logic                                                      lk_valid,
  output route_table_pkg::epid_t                                    lk_epid
);

  // Channel that owns the lookup in flight, also the last winner
  route_table_pkg::port_t owner;
  route_table_pkg::port_t grant_idx;
  logic                   grant_found;
  logic                   accept;
  logic                   lk_pend;
  logic                   res_pend;
  route_table_pkg::port_t res_port_q;
  logic                   res_hit_q;

  always_comb begin
    int j;
    grant_found = 1'b0;
    grant_idx   = owner;
    for (int k = route_table_pkg::NUM_PORTS; k >= 1; k--) begin
      j = (int'(owner) + k) % route_table_pkg::NUM_PORTS;
      if (find_valid[j]) begin
        grant_found = 1'b1;
        grant_idx   = j[route_table_pkg::PORT_W-1:0];
      end
    end
  end

  assign accept   = grant_found && !lk_pend && !res_pend;
  assign lk_valid = accept;
  assign lk_epid  = find_epid[grant_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      lk_pend  <= 1'b0;
      res_pend <= 1'b0;
      owner    <= route_table_pkg::port_t'(route_table_pkg::NUM_PORTS - 1);
    end else begin
      lk_pend <= accept;
      if (accept) begin
        owner <= grant_idx;
      end
      if (lk_pend) begin
        res_pend <= 1'b1;
      end else if (res_pend && result_ready[owner]) begin
        res_pend <= 1'b0;
      end
    end
  end

  // Table answer arrives the cycle after the request
  always_ff @(posedge clk) begin
    if (lk_pend) begin
      res_port_q <= lk_port;
      res_hit_q  <= lk_hit;
    end
  end

  // Steer handshakes and the held answer to the owning channel
  always_comb begin
    find_ready   = '0;
    result_valid = '0;
    result_port  = '0;
    result_hit   = '0;
    if (accept) begin
      find_ready[grant_idx] = 1'b1;
    end
    if (res_pend) begin
      result_valid[owner] = 1'b1;
      result_port[owner]  = res_port_q;
      result_hit[owner]   = res_hit_q;
    end
  end

  one_result : assert property (@(posedge clk) disable iff (reset) $onehot0(result_valid));

endmodule

`default_nettype wire

// File: verilog/route_table.sv
// ==============================
// Shared route table of the packet crossbar. Insertion ports
// write endpoint to port entries, lookup channels query them.
// ==============================
`timescale 1ns/100ps
`default_nettype none

module route_table (
  input  wire logic                                                     clk,
  input  wire logic                                                     reset,
  // Insertion ports of the crossbar ports
  input  wire logic [route_table_pkg::NUM_PORTS-1:0]                    port_req_wr,
  input  wire route_table_pkg::epid_t [route_table_pkg::NUM_PORTS-1:0]    port_req_addr,
  input  wire route_table_pkg::cfg_data_t [route_table_pkg::NUM_PORTS-1:0] port_req_data,
  output logic [route_table_pkg::NUM_PORTS-1:0]                         port_resp_ack,
  // External insertion port
  input  wire logic                                                     ext_req_wr,
  input  wire route_table_pkg::epid_t                                   ext_req_addr,
  input  wire route_table_pkg::cfg_data_t                               ext_req_data,
  output logic                                                          ext_resp_ack,
  // Lookup channels
  input  wire logic [route_table_pkg::NUM_PORTS-1:0]                    find_valid,
  input  wire route_table_pkg::epid_t [route_table_pkg::NUM_PORTS-1:0]    find_epid,
  output logic [route_table_pkg::NUM_PORTS-1:0]                         find_ready,
  output logic [route_table_pkg::NUM_PORTS-1:0]                         result_valid,
  output route_table_pkg::port_t [route_table_pkg::NUM_PORTS-1:0]       result_port,
  output logic [route_table_pkg::NUM_PORTS-1:0]                         result_hit,
  input  wire logic [route_table_pkg::NUM_PORTS-1:0]                    result_ready
);

  logic [route_table_pkg::NUM_INS_SRC-1:0]                   src_valid;
  route_table_pkg::epid_t [route_table_pkg::NUM_INS_SRC-1:0] src_epid;
  route_table_pkg::port_t [route_table_pkg::NUM_INS_SRC-1:0] src_port;
  logic [route_table_pkg::NUM_INS_SRC-1:0]                   src_take;

  logic                   ins_valid;
  logic                   ins_ready;
  route_table_pkg::epid_t ins_epid;
  route_table_pkg::port_t ins_port;
  logic                   lk_valid;
  route_table_pkg::epid_t lk_epid;
  route_table_pkg::port_t lk_port;
  logic                   lk_hit;

  // Crossbar port sources take arbiter indices 0 to NUM_PORTS-1
  for (genvar i = 0; i < route_table_pkg::NUM_PORTS; i++) begin : g_port_ins
    insert_request_port u_port_req (
      .clk        (clk),
      .reset      (reset),
      .req_wr     (port_req_wr[i]),
      .req_addr   (port_req_addr[i]),
      .req_data   (port_req_data[i]),
      .take       (src_take[i]),
      .held_valid (src_valid[i]),
      .held_epid  (src_epid[i]),
      .held_port  (src_port[i]),
      .resp_ack   (port_resp_ack[i])
    );
  end

  // External source is the last arbiter index
  insert_request_port u_ext_req (
    .clk        (clk),
    .reset      (reset),
    .req_wr     (ext_req_wr),
    .req_addr   (ext_req_addr),
    .req_data   (ext_req_data),
    .take       (src_take[route_table_pkg::NUM_PORTS]),
    .held_valid (src_valid[route_table_pkg::NUM_PORTS]),
    .held_epid  (src_epid[route_table_pkg::NUM_PORTS]),
    .held_port  (src_port[route_table_pkg::NUM_PORTS]),
    .resp_ack   (ext_resp_ack)
  );

  insert_arbiter u_ins_arb (
    .clk       (clk),
    .reset     (reset),
    .src_valid (src_valid),
    .src_epid  (src_epid),
    .src_port  (src_port),
    .ins_ready (ins_ready),
    .src_take  (src_take),
    .ins_valid (ins_valid),
    .ins_epid  (ins_epid),
    .ins_port  (ins_port)
  );

  route_cam u_cam (
    .clk       (clk),
    .reset     (reset),
    .ins_valid (ins_valid),
    .ins_epid  (ins_epid),
    .ins_port  (ins_port),
    .lk_valid  (lk_valid),
    .lk_epid   (lk_epid),
    .ins_ready (ins_ready),
    .lk_port   (lk_port),
    .lk_hit    (lk_hit)
  );

  find_arbiter u_find_arb (
    .clk          (clk),
    .reset        (reset),
    .find_valid   (find_valid),
    .find_epid    (find_epid),
    .result_ready (result_ready),
    .lk_port      (lk_port),
    .lk_hit       (lk_hit),
    .find_ready   (find_ready),
    .result_valid (result_valid),
    .result_port  (result_port),
    .result_hit   (result_hit),
    .lk_valid     (lk_valid),
    .lk_epid      (lk_epid)
  );

endmodule

`default_nettype wire

// File: tests/route_table_checker.sv
// ==============================
// Reference model of the route table for the testbench.
// Watches the DUT ports, tracks held strobes and lookups,
// and counts every mismatch.
// ==============================
`timescale 1ns/100ps
`default_nettype none

module route_table_checker (
  input  wire logic                                                      clk,
  input  wire logic                                                      reset,
  input  wire logic [2:0]                                                test_id,
  input  wire logic [route_table_pkg::NUM_INS_SRC-1:0]                   src_wr,
  input  wire route_table_pkg::epid_t [route_table_pkg::NUM_INS_SRC-1:0]    src_addr,
  input  wire route_table_pkg::cfg_data_t [route_table_pkg::NUM_INS_SRC-1:0] src_data,
  input  wire logic [route_table_pkg::NUM_INS_SRC-1:0]                   src_ack,
  input  wire logic [route_table_pkg::NUM_PORTS-1:0]                     find_valid,
  input  wire route_table_pkg::epid_t [route_table_pkg::NUM_PORTS-1:0]      find_epid,
  input  wire logic [route_table_pkg::NUM_PORTS-1:0]                     find_ready,
  input  wire logic [route_table_pkg::NUM_PORTS-1:0]                     result_valid,
  input  wire route_table_pkg::port_t [route_table_pkg::NUM_PORTS-1:0]      result_port,
  input  wire logic [route_table_pkg::NUM_PORTS-1:0]                     result_hit,
  input  wire logic [route_table_pkg::NUM_PORTS-1:0]                     result_ready,
  output int                                                             error_count,
  output int                                                             open_count
);

  logic                   model_valid [route_table_pkg::TABLE_DEPTH];
  route_table_pkg::epid_t model_key   [route_table_pkg::TABLE_DEPTH];
  route_table_pkg::port_t model_port  [route_table_pkg::TABLE_DEPTH];
  int                     repl_ptr;

  // Copy of each capture register
  logic                   held      [route_table_pkg::NUM_INS_SRC];
  route_table_pkg::epid_t held_key  [route_table_pkg::NUM_INS_SRC];
  route_table_pkg::port_t held_port [route_table_pkg::NUM_INS_SRC];

  // Expected answer of the lookup in flight per channel
  logic                   exp_valid [route_table_pkg::NUM_PORTS];
  logic                   exp_hit   [route_table_pkg::NUM_PORTS];
  route_table_pkg::port_t exp_port  [route_table_pkg::NUM_PORTS];

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "single_insert";
      3'd2:    return "miss";
      3'd3:    return "overwrite";
      3'd4:    return "capacity";
      3'd5:    return "concurrent";
      default: return "reset";
    endcase
  endfunction

  function automatic int slot_of(input route_table_pkg::epid_t key);
    int idx;
    idx = -1;
    for (int i = 0; i < route_table_pkg::TABLE_DEPTH; i++) begin
      if (idx < 0 && model_valid[i] && model_key[i] == key) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // Matching key, else lowest free slot, else the oldest replacement slot
  task automatic apply_insert(input route_table_pkg::epid_t key, input route_table_pkg::port_t port);
    int idx;
    idx = slot_of(key);
    if (idx < 0) begin
      for (int i = route_table_pkg::TABLE_DEPTH - 1; i >= 0; i--) begin
        if (!model_valid[i]) begin
          idx = i;
        end
      end
    end
    if (idx < 0) begin
      idx      = repl_ptr;
      repl_ptr = (repl_ptr + 1) % route_table_pkg::TABLE_DEPTH;
    end
    model_valid[idx] = 1'b1;
    model_key[idx]   = key;
    model_port[idx]  = port;
  endtask

  task automatic report_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("Error [%s] %s: expected %0h, actual %0h", test_name(test_id), what,
             expected, actual);
    error_count++;
  endtask

  task automatic report_fault(input string msg);
    $display("%s during test %s", msg, test_name(test_id));
    error_count++;
  endtask

  always @(posedge clk) begin
    int idx;
    int open;
    if (reset) begin
      for (int i = 0; i < route_table_pkg::TABLE_DEPTH; i++) begin
        model_valid[i] = 1'b0;
      end
      for (int s = 0; s < route_table_pkg::NUM_INS_SRC; s++) begin
        held[s] = 1'b0;
      end
      for (int ch = 0; ch < route_table_pkg::NUM_PORTS; ch++) begin
        exp_valid[ch] = 1'b0;
      end
      repl_ptr    = 0;
      error_count = 0;
    end else begin
      // Lookups first, a write in the same cycle is not visible yet
      for (int ch = 0; ch < route_table_pkg::NUM_PORTS; ch++) begin
        if (result_valid[ch] && result_ready[ch]) begin
          if (!exp_valid[ch]) begin
            report_fault($sformatf("Result on channel %0d with no lookup issued", ch));
          end else begin
            if (result_hit[ch] !== exp_hit[ch]) begin
              report_value($sformatf("channel %0d hit", ch), exp_hit[ch], result_hit[ch]);
            end
            if (result_port[ch] !== exp_port[ch]) begin
              report_value($sformatf("channel %0d port", ch), exp_port[ch], result_port[ch]);
            end
          end
          exp_valid[ch] = 1'b0;
        end
        if (find_ready[ch]) begin
          if (!find_valid[ch]) begin
            report_fault($sformatf("find_ready on channel %0d without a request", ch));
          end
          if (exp_valid[ch]) begin
            report_fault($sformatf("Second lookup on channel %0d before its result", ch));
          end
          idx           = slot_of(find_epid[ch]);
          exp_valid[ch] = 1'b1;
          exp_hit[ch]   = (idx >= 0);
          if (idx >= 0) begin
            exp_port[ch] = model_port[idx];
          end else begin
            exp_port[ch] = '0;
          end
        end
      end

      // Strobes are dropped while the capture register holds a request
      for (int s = 0; s < route_table_pkg::NUM_INS_SRC; s++) begin
        if (src_ack[s] && !held[s]) begin
          report_fault($sformatf("Ack on source %0d without a held strobe", s));
        end else if (src_ack[s]) begin
          apply_insert(held_key[s], held_port[s]);
          held[s] = 1'b0;
        end else if (!held[s] && src_wr[s]) begin
          held[s]      = 1'b1;
          held_key[s]  = src_addr[s];
          held_port[s] = src_data[s][route_table_pkg::PORT_W-1:0];
        end
      end
    end

    open = 0;
    for (int s = 0; s < route_table_pkg::NUM_INS_SRC; s++) begin
      if (held[s]) begin
        open++;
      end
    end
    for (int ch = 0; ch < route_table_pkg::NUM_PORTS; ch++) begin
      if (exp_valid[ch]) begin
        open++;
      end
    end
    open_count = open;
  end

endmodule

`default_nettype wire

// File: tests/route_table_tb.sv
// ==============================
// Testbench for the route table. Drives seeded random inserts
// and lookups, the checker module compares with its model.
// ==============================
`timescale 1ns/100ps
`default_nettype none

module route_table_tb;

  // Reset, single insert, miss, overwrite, concurrent and capacity lengths
  localparam int TEST_CYCLES = 10 + 130 + 60 + 130 + 240 + 990;
  localparam int CYCLE_LIMIT = TEST_CYCLES + 2000;
  localparam int QUIET       = 20;

  logic       clk     = 1'b0;
  logic       reset   = 1'b1;
  logic [2:0] test_id = 3'd0;

  logic [route_table_pkg::NUM_INS_SRC-1:0]                      src_wr   = '0;
  route_table_pkg::epid_t [route_table_pkg::NUM_INS_SRC-1:0]    src_addr = '0;
  route_table_pkg::cfg_data_t [route_table_pkg::NUM_INS_SRC-1:0] src_data = '0;
  logic [route_table_pkg::NUM_PORTS-1:0]                        port_ack;
  logic                                                         ext_ack;
  logic [route_table_pkg::NUM_INS_SRC-1:0]                      src_ack;

  logic [route_table_pkg::NUM_PORTS-1:0]                        find_valid   = '0;
  route_table_pkg::epid_t [route_table_pkg::NUM_PORTS-1:0]      find_epid    = '0;
  logic [route_table_pkg::NUM_PORTS-1:0]                        result_ready = '1;
  logic [route_table_pkg::NUM_PORTS-1:0]                        find_ready;
  logic [route_table_pkg::NUM_PORTS-1:0]                        result_valid;
  route_table_pkg::port_t [route_table_pkg::NUM_PORTS-1:0]      result_port;
  logic [route_table_pkg::NUM_PORTS-1:0]                        result_hit;

  int   cycle_count;
  int   error_count;
  int   open_count;
  logic bursts_done = 1'b0;

  route_table_pkg::epid_t stable_keys[$];
  route_table_pkg::epid_t other_keys[$];

  assign src_ack = {ext_ack, port_ack};

  route_table dut (
    .clk           (clk),
    .reset         (reset),
    .port_req_wr   (src_wr[route_table_pkg::NUM_PORTS-1:0]),
    .port_req_addr (src_addr[route_table_pkg::NUM_PORTS-1:0]),
    .port_req_data (src_data[route_table_pkg::NUM_PORTS-1:0]),
    .port_resp_ack (port_ack),
    .ext_req_wr    (src_wr[route_table_pkg::NUM_PORTS]),
    .ext_req_addr  (src_addr[route_table_pkg::NUM_PORTS]),
    .ext_req_data  (src_data[route_table_pkg::NUM_PORTS]),
    .ext_resp_ack  (ext_ack),
    .find_valid    (find_valid),
    .find_epid     (find_epid),
    .find_ready    (find_ready),
    .result_valid  (result_valid),
    .result_port   (result_port),
    .result_hit    (result_hit),
    .result_ready  (result_ready)
  );

  route_table_checker chk (
    .clk          (clk),
    .reset        (reset),
    .test_id      (test_id),
    .src_wr       (src_wr),
    .src_addr     (src_addr),
    .src_data     (src_data),
    .src_ack      (src_ack),
    .find_valid   (find_valid),
    .find_epid    (find_epid),
    .find_ready   (find_ready),
    .result_valid (result_valid),
    .result_port  (result_port),
    .result_hit   (result_hit),
    .result_ready (result_ready),
    .error_count  (error_count),
    .open_count   (open_count)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    if (reset) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("tests failed");
        $finish;
      end
    end
  end

  // One cycle write strobe with random upper data bits
  task automatic strobe_source(input int src, input route_table_pkg::epid_t key);
    @(posedge clk);
    src_wr[src]   <= 1'b1;
    src_addr[src] <= key;
    src_data[src] <= $urandom;
    @(posedge clk);
    src_wr[src] <= 1'b0;
  endtask

  task automatic insert_entry(input int src, input route_table_pkg::epid_t key);
    strobe_source(src, key);
    do @(posedge clk); while (!src_ack[src]);
  endtask

  task automatic lookup_key(input int ch, input route_table_pkg::epid_t key);
    @(posedge clk);
    find_valid[ch] <= 1'b1;
    find_epid[ch]  <= key;
    do @(posedge clk); while (!find_ready[ch]);
    find_valid[ch] <= 1'b0;
    do @(posedge clk); while (!(result_valid[ch] && result_ready[ch]));
  endtask

  // Fresh keys, some strobes land while the port is still busy
  task automatic burst_source(input int src);
    route_table_pkg::epid_t key;
    for (int n = 0; n < 6; n++) begin
      key = {4'h5, 12'($urandom)};
      other_keys.push_back(key);
      strobe_source(src, key);
      repeat ($urandom % 3) @(posedge clk);
    end
  endtask

  task automatic burst_lookups(input int ch);
    route_table_pkg::epid_t key;
    for (int n = 0; n < 6; n++) begin
      if (n % 2 == 0) begin
        key = stable_keys[$urandom % stable_keys.size()];
      end else begin
        key = {4'hF, 12'($urandom)};
      end
      lookup_key(ch, key);
    end
  endtask

  task automatic randomize_ready();
    while (!bursts_done) begin
      @(posedge clk);
      result_ready <= 4'($urandom);
    end
    result_ready <= '1;
  endtask

  initial begin
    route_table_pkg::epid_t key;
    void'($urandom(32'h254));
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    test_id <= 3'd1;
    for (int r = 0; r < 2; r++) begin
      for (int s = 0; s < route_table_pkg::NUM_INS_SRC; s++) begin
        key = {4'h1, 12'($urandom)};
        stable_keys.push_back(key);
        insert_entry(s, key);
      end
    end
    repeat (QUIET) @(posedge clk);
    foreach (stable_keys[i]) lookup_key($urandom % route_table_pkg::NUM_PORTS, stable_keys[i]);

    // Keys outside every inserted range
    test_id <= 3'd2;
    repeat (12) lookup_key($urandom % route_table_pkg::NUM_PORTS, {4'hF, 12'($urandom)});

    test_id <= 3'd3;
    foreach (stable_keys[i]) insert_entry($urandom % route_table_pkg::NUM_INS_SRC, stable_keys[i]);
    repeat (QUIET) @(posedge clk);
    foreach (stable_keys[i]) lookup_key($urandom % route_table_pkg::NUM_PORTS, stable_keys[i]);

    // All sources and channels at once, table stays below capacity
    test_id <= 3'd5;
    fork
      begin
        fork
          burst_source(0);
          burst_source(1);
          burst_source(2);
          burst_source(3);
          burst_source(4);
          burst_lookups(0);
          burst_lookups(1);
          burst_lookups(2);
          burst_lookups(3);
        join
        bursts_done = 1'b1;
      end
      randomize_ready();
    join
    repeat (2 * QUIET) @(posedge clk);

    test_id <= 3'd4;
    for (int i = 0; i < 70; i++) begin
      key = {4'h8, 12'(i)};
      other_keys.push_back(key);
      insert_entry($urandom % route_table_pkg::NUM_INS_SRC, key);
    end
    repeat (QUIET) @(posedge clk);
    foreach (stable_keys[i]) lookup_key($urandom % route_table_pkg::NUM_PORTS, stable_keys[i]);
    foreach (other_keys[i]) lookup_key($urandom % route_table_pkg::NUM_PORTS, other_keys[i]);

    repeat (QUIET) @(posedge clk);
    if (open_count != 0) begin
      $display("Some strobes or lookups got no response by the end of the run");
    end
    $display("Errors: %0d, open requests: %0d", error_count, open_count);
    if (error_count == 0 && open_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
verilog/route_table_pkg.sv
verilog/insert_request_port.sv
verilog/insert_arbiter.sv
verilog/route_cam.sv
verilog/find_arbiter.sv
verilog/route_table.sv
tests/route_table_checker.sv
tests/route_table_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the route table testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module route_table_tb \
  -f sources.f \
  -o route_table_sim

./obj_dir/route_table_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
